//--- hw/scv_params.svh
/*
 * bus widths, memory sizes and address map boundaries
 * CPU and audio clock divider constants
 */
`ifndef SCV_PARAMS_SVH
`define SCV_PARAMS_SVH

// CPU bus and init port
`define SCV_DW        8
`define SCV_AW        16
`define SCV_INIT_AW   17

// memory address widths
`define SCV_BOOT_AW   12
`define SCV_WRAM_AW   7
`define SCV_CART_AW   17

// address map
`define SCV_VDC_BASE  16'h2000
`define SCV_VDC_LAST  16'h35FF
`define SCV_APU_BASE  16'h3600
`define SCV_APU_LAST  16'h37FF
`define SCV_CART_BASE 16'h8000
`define SCV_WRAM_BASE 16'hFF80
`define SCV_OPEN_BUS  8'hFF

// clocking
`define SCV_CPU_DIV   14
`define SCV_AUD_NUM   22
`define SCV_AUD_DEN   82

`endif

//--- hw/scv_pkg.sv
/*
 * shared types for the console memory and bus core
 * cartridge mapper modes and CPU bus regions
 */
package scv_pkg;

  // cart banking scheme set per cartridge
  typedef enum logic [1:0] {
    MAPPER_32K  = 2'd0,  // flat 32 KiB
    MAPPER_64K  = 2'd1,  // PC5 selects the upper half
    MAPPER_128K = 2'd2   // PC6..PC5 select one of four banks
  } mapper_t;

  //////////////////////////////////////////////////
  // CPU address regions
  //////////////////////////////////////////////////

  typedef enum logic [2:0] {
    REG_BOOT = 3'd0,  // internal boot ROM
    REG_WRAM = 3'd1,  // 128 byte work RAM at the top of the map
    REG_CART = 3'd2,
    REG_VDC  = 3'd3,  // video controller registers and VRAM
    REG_APU  = 3'd4,  // sound processor port
    REG_OPEN = 3'd5   // nothing decoded here
  } region_t;

endpackage

//--- hw/scv_clkgen.sv
/*
 * master clock divider
 * two-phase CPU edge enables, VDC enable and fractional audio enable
 */
`timescale 1ns/1ps
`include "scv_params.svh"

module scv_clkgen (
  input  logic CLK,
  input  logic rst_i,
  output logic cp1_pos_o,
  output logic cp1_neg_o,
  output logic cp2_pos_o,
  output logic cp2_neg_o,
  output logic vdc_ce_o,
  output logic aud_ce_o
);

  localparam int CNT_W = $clog2(`SCV_CPU_DIV);
  localparam int ACC_W = $clog2(`SCV_AUD_NUM + `SCV_AUD_DEN);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCV_CPU_DIV - 1);
  localparam logic [ACC_W-1:0] AUD_STEP = ACC_W'(`SCV_AUD_NUM);
  localparam logic [ACC_W-1:0] AUD_DEN  = ACC_W'(`SCV_AUD_DEN);

  // phase edge positions within one CPU cycle
  localparam int CP2_NEG_AT = 0;
  localparam int CP1_POS_AT = 2;
  localparam int CP1_NEG_AT = 4;
  localparam int CP2_POS_AT = 6;
  localparam int VDC_A_AT   = 2;   // VDC runs at twice the CPU rate
  localparam int VDC_B_AT   = 9;

  logic [CNT_W-1:0] cnt;  // position in the 14 clock CPU cycle
  logic [ACC_W-1:0] acc;  // audio phase accumulator

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      cnt <= '0;
      acc <= '0;
    end else begin
      cnt <= (cnt == CNT_LAST) ? '0 : cnt + 1'b1;
      acc <= aud_ce_o ? acc - AUD_DEN : acc + AUD_STEP;
    end
  end

  assign cp2_neg_o = (cnt == CNT_W'(CP2_NEG_AT));
  assign cp1_pos_o = (cnt == CNT_W'(CP1_POS_AT));
  assign cp1_neg_o = (cnt == CNT_W'(CP1_NEG_AT));
  assign cp2_pos_o = (cnt == CNT_W'(CP2_POS_AT));
  assign vdc_ce_o  = (cnt == CNT_W'(VDC_A_AT)) || (cnt == CNT_W'(VDC_B_AT));
  assign aud_ce_o  = (acc >= AUD_DEN);  // 22 of every 82 clocks

  // after a subtract the accumulator is below 22 and cannot reach 82 next clock
  a_aud_ce_isolated: assert property (@(posedge CLK) disable iff (rst_i)
    aud_ce_o |=> !aud_ce_o);

endmodule

//--- hw/scv_sync_ram.sv
/*
 * byte-wide synchronous RAM with registered read
 * CPU write port plus an init write port for loading images
 */
`timescale 1ns/1ps
`include "scv_params.svh"

module scv_sync_ram #(
  parameter int AW = 8
) (
  input  logic               CLK,
  input  logic               we_i,
  input  logic [AW-1:0]      addr_i,
  input  logic [`SCV_DW-1:0] wdata_i,
  input  logic               init_we_i,
  input  logic [AW-1:0]      init_addr_i,
  input  logic [`SCV_DW-1:0] init_data_i,
  output logic [`SCV_DW-1:0] rdata_o
);

  localparam int DEPTH = 1 << AW;

  logic [`SCV_DW-1:0] mem [DEPTH];

  // contents start at zero until loaded
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  // init port wins when both ports write
  always @(posedge CLK) begin
    if (init_we_i) begin
      mem[init_addr_i] <= init_data_i;
    end else if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  always_ff @(posedge CLK) begin
    rdata_o <= mem[addr_i];  // old byte on a same-edge write
  end

endmodule

//--- hw/scv_cart.sv
/*
 * cartridge slot
 * mapper bank selection from port C and the cart ROM
 */
`timescale 1ns/1ps
`include "scv_params.svh"

module scv_cart (
  input  logic                    CLK,
  input  logic [14:0]             addr_i,      // CPU A14..A0
  input  scv_pkg::mapper_t        mapper_i,
  input  logic [1:0]              port_c_i,    // PC6..PC5
  input  logic                    init_we_i,
  input  logic [`SCV_CART_AW-1:0] init_addr_i,
  input  logic [`SCV_DW-1:0]      init_data_i,
  output logic [`SCV_DW-1:0]      rdata_o
);

  import scv_pkg::*;

  logic [1:0]              bank;      // ROM A16..A15
  logic [`SCV_CART_AW-1:0] rom_addr;

  //////////////////////////////////////////////////
  // mapper
  //////////////////////////////////////////////////

  always_comb begin
    case (mapper_i)
      MAPPER_64K:  bank = {1'b0, port_c_i[0]};
      MAPPER_128K: bank = port_c_i;
      default:     bank = 2'b00;   // 32K carts and the spare code
    endcase
  end

  assign rom_addr = {bank, addr_i};

  //////////////////////////////////////////////////
  // ROM
  //////////////////////////////////////////////////

  // the CPU never writes the cart, only the loader does
  scv_sync_ram #(
    .AW (`SCV_CART_AW)
  ) u_rom (
    .CLK         (CLK),
    .we_i        (1'b0),
    .addr_i      (rom_addr),
    .wdata_i     ('0),
    .init_we_i   (init_we_i),
    .init_addr_i (init_addr_i),
    .init_data_i (init_data_i),
    .rdata_o     (rdata_o)
  );

endmodule

//--- hw/scv_bus.sv
/*
 * CPU address decoder, chip selects and work RAM write enable
 * registered read-return mux with fixed one-cycle latency
 */
`timescale 1ns/1ps
`include "scv_params.svh"

module scv_bus (
  input  logic               CLK,
  input  logic               rst_i,
  input  logic [`SCV_AW-1:0] addr_i,
  input  logic               rd_i,
  input  logic               wr_i,
  input  logic [`SCV_DW-1:0] ext_rdata_i,
  input  logic [`SCV_DW-1:0] boot_rdata_i,
  input  logic [`SCV_DW-1:0] wram_rdata_i,
  input  logic [`SCV_DW-1:0] cart_rdata_i,
  output logic               wram_we_o,
  output logic               vdc_cs_o,
  output logic               apu_cs_o,
  output logic [`SCV_DW-1:0] rdata_o,
  output logic               rvalid_o
);

  import scv_pkg::*;

  region_t            region;     // decode of the current address
  region_t            region_q;   // region of the read in flight
  logic               rd_q;
  logic [`SCV_DW-1:0] ext_q;      // VDC/APU byte taken at the strobe
  logic [`SCV_DW-1:0] rdata_mux;
  logic               access;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  always_comb begin
    if (addr_i[`SCV_AW-1:`SCV_BOOT_AW] == '0) begin
      region = REG_BOOT;
    end else if (addr_i >= `SCV_VDC_BASE && addr_i <= `SCV_VDC_LAST) begin
      region = REG_VDC;
    end else if (addr_i >= `SCV_APU_BASE && addr_i <= `SCV_APU_LAST) begin
      region = REG_APU;
    end else if (addr_i >= `SCV_WRAM_BASE) begin
      region = REG_WRAM;   // carved out of the top of cart space
    end else if (addr_i >= `SCV_CART_BASE) begin
      region = REG_CART;
    end else begin
      region = REG_OPEN;
    end
  end

  assign access    = rd_i || wr_i;
  assign wram_we_o = wr_i && (region == REG_WRAM);
  assign vdc_cs_o  = access && (region == REG_VDC);
  assign apu_cs_o  = access && (region == REG_APU);

  //////////////////////////////////////////////////
  // read return
  //////////////////////////////////////////////////

  always_comb begin
    case (region_q)
      REG_BOOT: rdata_mux = boot_rdata_i;
      REG_WRAM: rdata_mux = wram_rdata_i;
      REG_CART: rdata_mux = cart_rdata_i;
      REG_VDC,
      REG_APU:  rdata_mux = ext_q;
      default:  rdata_mux = `SCV_OPEN_BUS;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      rd_q     <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      rd_q     <= rd_i;
      rvalid_o <= rd_q;
    end
  end

  // stage 1 at the strobe, stage 2 once the memories have answered
  always_ff @(posedge CLK) begin
    if (rd_i) begin
      region_q <= region;
      ext_q    <= ext_rdata_i;
    end
    if (rd_q) begin
      rdata_o <= rdata_mux;
    end
  end

  a_rd_wr_exclusive: assert property (@(posedge CLK) disable iff (rst_i)
    !(rd_i && wr_i));

endmodule

//--- hw/scv_mem_top.sv
/*
 * memory and bus top level
 * clock enables, boot ROM, work RAM, cartridge and bus decode
 */
`timescale 1ns/1ps
`include "scv_params.svh"

module scv_mem_top (
  input  logic                   CLK,
  input  logic                   rst_i,
  input  logic [`SCV_AW-1:0]     addr_i,
  input  logic [`SCV_DW-1:0]     wdata_i,
  input  logic                   rd_i,
  input  logic                   wr_i,
  input  logic [`SCV_DW-1:0]     ext_rdata_i,   // from VDC or APU
  input  scv_pkg::mapper_t       mapper_i,
  input  logic [7:0]             port_c_i,      // CPU port C output
  input  logic                   init_sel_boot_i,
  input  logic                   init_sel_cart_i,
  input  logic [`SCV_INIT_AW-1:0] init_addr_i,
  input  logic [`SCV_DW-1:0]     init_data_i,
  input  logic                   init_valid_i,
  output logic                   cp1_pos_o,
  output logic                   cp1_neg_o,
  output logic                   cp2_pos_o,
  output logic                   cp2_neg_o,
  output logic                   vdc_ce_o,
  output logic                   aud_ce_o,
  output logic                   vdc_cs_o,
  output logic                   apu_cs_o,
  output logic [`SCV_DW-1:0]     rdata_o,
  output logic                   rvalid_o
);

  logic               init_boot_we;
  logic               init_cart_we;
  logic               wram_we;
  logic [`SCV_DW-1:0] boot_rdata;
  logic [`SCV_DW-1:0] wram_rdata;
  logic [`SCV_DW-1:0] cart_rdata;

  assign init_boot_we = init_valid_i && init_sel_boot_i;
  assign init_cart_we = init_valid_i && init_sel_cart_i;

  scv_clkgen u_clkgen (
    .CLK       (CLK),
    .rst_i     (rst_i),
    .cp1_pos_o (cp1_pos_o),
    .cp1_neg_o (cp1_neg_o),
    .cp2_pos_o (cp2_pos_o),
    .cp2_neg_o (cp2_neg_o),
    .vdc_ce_o  (vdc_ce_o),
    .aud_ce_o  (aud_ce_o)
  );

  //////////////////////////////////////////////////
  // memories
  //////////////////////////////////////////////////

  scv_sync_ram #(
    .AW (`SCV_BOOT_AW)
  ) u_boot (
    .CLK         (CLK),
    .we_i        (1'b0),                        // ROM to the CPU
    .addr_i      (addr_i[`SCV_BOOT_AW-1:0]),
    .wdata_i     ('0),
    .init_we_i   (init_boot_we),
    .init_addr_i (init_addr_i[`SCV_BOOT_AW-1:0]),
    .init_data_i (init_data_i),
    .rdata_o     (boot_rdata)
  );

  scv_sync_ram #(
    .AW (`SCV_WRAM_AW)
  ) u_wram (
    .CLK         (CLK),
    .we_i        (wram_we),
    .addr_i      (addr_i[`SCV_WRAM_AW-1:0]),
    .wdata_i     (wdata_i),
    .init_we_i   (1'b0),
    .init_addr_i ('0),
    .init_data_i ('0),
    .rdata_o     (wram_rdata)
  );

  scv_cart u_cart (
    .CLK         (CLK),
    .addr_i      (addr_i[14:0]),
    .mapper_i    (mapper_i),
    .port_c_i    (port_c_i[6:5]),   // bank bits
    .init_we_i   (init_cart_we),
    .init_addr_i (init_addr_i[`SCV_CART_AW-1:0]),
    .init_data_i (init_data_i),
    .rdata_o     (cart_rdata)
  );

  //////////////////////////////////////////////////
  // bus decode and read return
  //////////////////////////////////////////////////

  scv_bus u_bus (
    .CLK          (CLK),
    .rst_i        (rst_i),
    .addr_i       (addr_i),
    .rd_i         (rd_i),
    .wr_i         (wr_i),
    .ext_rdata_i  (ext_rdata_i),
    .boot_rdata_i (boot_rdata),
    .wram_rdata_i (wram_rdata),
    .cart_rdata_i (cart_rdata),
    .wram_we_o    (wram_we),
    .vdc_cs_o     (vdc_cs_o),
    .apu_cs_o     (apu_cs_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o)
  );

  // loader may run while the core is held in reset
  a_init_sel_onehot: assert property (@(posedge CLK)
    init_valid_i |-> !(init_sel_boot_i && init_sel_cart_i));

endmodule

//--- verification/scv_tb.sv
/*
 * testbench for the memory and bus top level
 * random init, bus and mapper stimulus checked against a reference model
 * clock enable model checks and a watchdog
 */
`timescale 1ns/1ps

module scv_tb;

  import scv_pkg::*;

  localparam int CE_CYCLES = 14 * 82;
  localparam int N_BOOT    = 1000;
  localparam int N_WRAM    = 800;
  localparam int N_IGN     = 200;   // write then read back
  localparam int N_OPEN    = 300;
  localparam int N_MAP     = 400;   // per mapper mode
  localparam int N_EXT     = 300;
  localparam int INIT_OPS  = 4096 + 131072;
  localparam int BUS_OPS   = CE_CYCLES + 2 * (N_BOOT + N_WRAM + 2 * N_IGN + N_OPEN
                             + 3 * N_MAP + N_EXT);   // x2 covers random idles
  localparam int WATCHDOG_NS = (INIT_OPS + BUS_OPS + 200) * 8 + 2000;

  logic        CLK;
  logic        rst_i;
  logic [15:0] addr_i;
  logic [7:0]  wdata_i;
  logic        rd_i;
  logic        wr_i;
  logic [7:0]  ext_rdata_i;
  mapper_t     mapper_i;
  logic [7:0]  port_c_i;
  logic        init_sel_boot_i;
  logic        init_sel_cart_i;
  logic [16:0] init_addr_i;
  logic [7:0]  init_data_i;
  logic        init_valid_i;
  logic        cp1_pos_o;
  logic        cp1_neg_o;
  logic        cp2_pos_o;
  logic        cp2_neg_o;
  logic        vdc_ce_o;
  logic        aud_ce_o;
  logic        vdc_cs_o;
  logic        apu_cs_o;
  logic [7:0]  rdata_o;
  logic        rvalid_o;

  // reference model
  logic [7:0] boot_m [4096];
  logic [7:0] wram_m [128];
  logic [7:0] cart_m [131072];
  logic [7:0] exp_q [$];           // expected read bytes in issue order
  integer     seed = 34;
  int         n_checks = 0;
  int         n_errors = 0;
  int         cnt_m;               // CPU phase position
  int         acc_m;               // audio accumulator
  int         vdc_seen;
  logic       rd_d1;               // read strobe one clock back
  logic       rd_d2;               // read strobe two clocks back

  scv_mem_top u_scv_mem_top (
    .CLK             (CLK),
    .rst_i           (rst_i),
    .addr_i          (addr_i),
    .wdata_i         (wdata_i),
    .rd_i            (rd_i),
    .wr_i            (wr_i),
    .ext_rdata_i     (ext_rdata_i),
    .mapper_i        (mapper_i),
    .port_c_i        (port_c_i),
    .init_sel_boot_i (init_sel_boot_i),
    .init_sel_cart_i (init_sel_cart_i),
    .init_addr_i     (init_addr_i),
    .init_data_i     (init_data_i),
    .init_valid_i    (init_valid_i),
    .cp1_pos_o       (cp1_pos_o),
    .cp1_neg_o       (cp1_neg_o),
    .cp2_pos_o       (cp2_pos_o),
    .cp2_neg_o       (cp2_neg_o),
    .vdc_ce_o        (vdc_ce_o),
    .aud_ce_o        (aud_ce_o),
    .vdc_cs_o        (vdc_cs_o),
    .apu_cs_o        (apu_cs_o),
    .rdata_o         (rdata_o),
    .rvalid_o        (rvalid_o)
  );

  initial CLK = 1'b0;
  always #4 CLK = ~CLK;

  //////////////////////////////////////////////////
  // model functions
  //////////////////////////////////////////////////

  function automatic int rand_word();
    return $random(seed);
  endfunction

  function automatic region_t region_of(input logic [15:0] a);
    if (a <= 16'h0FFF) begin
      return REG_BOOT;
    end else if (a >= 16'h2000 && a <= 16'h35FF) begin
      return REG_VDC;
    end else if (a >= 16'h3600 && a <= 16'h37FF) begin
      return REG_APU;
    end else if (a >= 16'hFF80) begin
      return REG_WRAM;
    end else if (a >= 16'h8000) begin
      return REG_CART;
    end
    return REG_OPEN;
  endfunction

  function automatic logic [7:0] expect_read(input logic [15:0] a, input mapper_t m,
                                             input logic [7:0] pc, input logic [7:0] ext);
    logic [1:0] bank;
    case (m)
      MAPPER_64K:  bank = {1'b0, pc[5]};
      MAPPER_128K: bank = pc[6:5];
      default:     bank = 2'b00;
    endcase
    case (region_of(a))
      REG_BOOT: return boot_m[a[11:0]];
      REG_WRAM: return wram_m[a[6:0]];
      REG_CART: return cart_m[{bank, a[14:0]}];
      REG_VDC,
      REG_APU:  return ext;
      default:  return 8'hFF;   // open bus
    endcase
  endfunction

  //////////////////////////////////////////////////
  // checks and bus tasks
  //////////////////////////////////////////////////

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    assert (got === exp) else begin
      $display("Error: time %0t %s got %b expected %b", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic idle_cycle();
    int r;
    r = rand_word();
    @(posedge CLK);
    rd_i        <= 1'b0;
    wr_i        <= 1'b0;
    ext_rdata_i <= r[7:0];   // garbage, must not reach rdata_o
  endtask

  task automatic maybe_idle();
    int r;
    r = rand_word();
    if (r[1:0] == 2'b00) begin
      idle_cycle();
    end
  endtask

  task automatic issue_read(input logic [15:0] a, input mapper_t m, input logic [7:0] pc);
    int r;
    r = rand_word();
    @(posedge CLK);
    addr_i      <= a;
    rd_i        <= 1'b1;
    wr_i        <= 1'b0;
    mapper_i    <= m;
    port_c_i    <= pc;
    ext_rdata_i <= r[7:0];
    exp_q.push_back(expect_read(a, m, pc, r[7:0]));
    maybe_idle();
  endtask

  task automatic issue_write(input logic [15:0] a, input logic [7:0] d);
    @(posedge CLK);
    addr_i  <= a;
    wdata_i <= d;
    wr_i    <= 1'b1;
    rd_i    <= 1'b0;
    if (region_of(a) == REG_WRAM) begin
      wram_m[a[6:0]] = d;   // every other region ignores the data
    end
    maybe_idle();
  endtask

  task automatic load_byte(input logic to_boot, input logic [16:0] a, input logic [7:0] d);
    @(posedge CLK);
    init_valid_i    <= 1'b1;
    init_sel_boot_i <= to_boot;
    init_sel_cart_i <= !to_boot;
    init_addr_i     <= a;
    init_data_i     <= d;
    if (to_boot) begin
      boot_m[a[11:0]] = d;
    end else begin
      cart_m[a] = d;
    end
  endtask

  //////////////////////////////////////////////////
  // clock enable model and output monitor
  //////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (rst_i) begin
      cnt_m <= 0;
      acc_m <= 0;
    end else begin
      cnt_m <= (cnt_m == 13) ? 0 : cnt_m + 1;
      acc_m <= (acc_m >= 82) ? acc_m - 82 : acc_m + 22;
    end
  end

  always @(negedge CLK) begin
    if (rst_i) begin
      vdc_seen = 0;
      rd_d1    = 1'b0;
      rd_d2    = 1'b0;
    end else begin
      check_bit("cp2_neg_o", cp2_neg_o, cnt_m == 0);
      check_bit("cp1_pos_o", cp1_pos_o, cnt_m == 2);
      check_bit("cp1_neg_o", cp1_neg_o, cnt_m == 4);
      check_bit("cp2_pos_o", cp2_pos_o, cnt_m == 6);
      check_bit("aud_ce_o", aud_ce_o, acc_m >= 82);
      if (vdc_ce_o) begin
        vdc_seen = vdc_seen + 1;
      end
      if (cnt_m == 13) begin   // end of one CPU cycle
        n_checks++;
        assert (vdc_seen == 2) else begin
          $display("Error: time %0t vdc_ce_o pulses got %0d expected 2", $time, vdc_seen);
          n_errors++;
        end
        vdc_seen = 0;
      end
      // strobe taken at edge N answers after edge N+1
      check_bit("rvalid_o", rvalid_o, rd_d2);
      rd_d2 = rd_d1;
      rd_d1 = rd_i;
    end
    check_bit("vdc_cs_o", vdc_cs_o, (rd_i || wr_i) && region_of(addr_i) == REG_VDC);
    check_bit("apu_cs_o", apu_cs_o, (rd_i || wr_i) && region_of(addr_i) == REG_APU);
    if (rvalid_o) begin
      n_checks++;
      assert (exp_q.size() != 0) else begin
        $display("rvalid_o went high at time %0t with no read outstanding", $time);
        n_errors++;
      end
      if (exp_q.size() != 0) begin
        check_byte("rdata_o", rdata_o, exp_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the test sequence finished");
    $display("TESTBENCH FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int          r;
    logic [15:0] a;
    mapper_t     m;
    rst_i           = 1'b1;
    addr_i          = '0;
    wdata_i         = '0;
    rd_i            = 1'b0;
    wr_i            = 1'b0;
    ext_rdata_i     = '0;
    mapper_i        = MAPPER_32K;
    port_c_i        = '0;
    init_sel_boot_i = 1'b0;
    init_sel_cart_i = 1'b0;
    init_addr_i     = '0;
    init_data_i     = '0;
    init_valid_i    = 1'b0;
    for (int i = 0; i < 128; i++) begin
      wram_m[i] = 8'h00;   // RAM powers up zeroed
    end
    repeat (5) @(posedge CLK);
    rst_i <= 1'b0;
    repeat (CE_CYCLES) @(posedge CLK);   // quiet bus, enables only

    for (int i = 0; i < 4096; i++) begin
      r = rand_word();
      load_byte(1'b1, i[16:0], r[7:0]);
    end
    for (int i = 0; i < 131072; i++) begin
      r = rand_word();
      load_byte(1'b0, i[16:0], r[7:0]);
    end
    @(posedge CLK);
    init_valid_i <= 1'b0;

    for (int i = 0; i < N_BOOT; i++) begin
      r = rand_word();
      issue_read({4'h0, r[11:0]}, MAPPER_32K, r[23:16]);
    end
    for (int i = 0; i < N_WRAM; i++) begin
      r = rand_word();
      a = {9'h1FF, r[6:0]};
      if (r[8]) begin
        issue_write(a, r[23:16]);
      end else begin
        issue_read(a, MAPPER_32K, 8'h00);
      end
    end
    for (int i = 0; i < N_IGN; i++) begin
      r = rand_word();
      a = r[20] ? {4'h0, r[11:0]} : {1'b1, r[14:0]};
      issue_write(a, r[31:24]);
      issue_read(a, MAPPER_128K, {1'b0, r[22:21], 5'b00000});
    end
    for (int i = 0; i < N_OPEN; i++) begin
      r = rand_word();
      a = r[16] ? {4'h1, r[11:0]} : {1'b0, r[14:0]};
      if (!r[16] && a < 16'h3800) begin
        a = a | 16'h4000;   // fold into 0x4000..0x77FF
      end
      issue_read(a, MAPPER_32K, 8'h00);
    end
    for (int k = 0; k < 3; k++) begin
      m = mapper_t'(k[1:0]);
      for (int i = 0; i < N_MAP; i++) begin
        r = rand_word();
        issue_read({1'b1, r[14:0]}, m, r[23:16]);
      end
    end
    for (int i = 0; i < N_EXT; i++) begin
      r = rand_word();
      a = r[9] ? 16'h2000 + {3'b000, r[12:0] % 13'h1600} : {7'b0011011, r[8:0]};
      if (r[10]) begin
        issue_write(a, r[31:24]);
      end else begin
        issue_read(a, MAPPER_32K, 8'h00);
      end
    end
    idle_cycle();
    while (exp_q.size() != 0) begin
      @(posedge CLK);
    end
    repeat (4) @(posedge CLK);   // catch any stray rvalid_o

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+hw
hw/scv_pkg.sv
hw/scv_clkgen.sv
hw/scv_sync_ram.sv
hw/scv_cart.sv
hw/scv_bus.sv
hw/scv_mem_top.sv
verification/scv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# success is decided by the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f flist.f --top-module scv_tb -o scv_sim \
  && ./obj_dir/scv_sim | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null \
  && echo "simulation ok" \
  || { echo "simulation did not pass"; exit 1; }
